//--- frame_parser.sv
`timescale 1ns/1ps

module frame_parser (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rcv,
	input  logic [7:0]            data,
	output logic                  hdr_valid,
	output frame_pkg::frame_hdr_t hdr,
	output frame_pkg::payload_t   payload,
	output logic                  frame_done,
	output logic                  frame_err
);

	typedef enum logic [3:0] {
		S_HUNT, S_E, S_SEP_CMD, S_CMD_HI, S_CMD_LO, S_SEP_CNT, S_CNT_HI,
		S_CNT_LO, S_SEP_PAY, S_PAY_HI, S_PAY_LO, S_TAIL_US, S_TAIL_E, S_TAIL_F
	} state_e;

	state_e     state, next;
	logic       bad;
	logic       hex_ok;
	logic [3:0] nib;
	logic [3:0] hi_nib;
	logic [7:0] remain;
	logic       pay_valid;
	logic [7:0] pay_byte;

	function automatic logic [4:0] hex_val(input logic [7:0] c);
		if (c >= frame_pkg::CH_0 && c <= frame_pkg::CH_9)
			return {1'b1, c[3:0]};
		if ((c >= frame_pkg::CH_A && c <= frame_pkg::CH_F) ||
		    (c >= frame_pkg::CH_LA && c <= frame_pkg::CH_LF))
			return {1'b1, c[3:0] + 4'd9}; // 'A' and 'a' both have low nibble 1
		return 5'd0;
	endfunction

	assign {hex_ok, nib} = hex_val(data);
	assign payload = '{valid: pay_valid, data: pay_byte};

	always_comb begin
		next = state;
		bad  = 1'b0;
		if (rcv) begin
			unique case (state)
				S_HUNT:    if (data == frame_pkg::CH_F) next = S_E; // anything else is skipped
				S_E:       begin bad = data != frame_pkg::CH_E;  next = S_SEP_CMD; end
				S_SEP_CMD: begin bad = data != frame_pkg::CH_US; next = S_CMD_HI;  end
				S_CMD_HI:  begin bad = !hex_ok;                  next = S_CMD_LO;  end
				S_CMD_LO:  begin bad = !hex_ok;                  next = S_SEP_CNT; end
				S_SEP_CNT: begin bad = data != frame_pkg::CH_US; next = S_CNT_HI;  end
				S_CNT_HI:  begin bad = !hex_ok;                  next = S_CNT_LO;  end
				S_CNT_LO:  begin bad = !hex_ok;                  next = S_SEP_PAY; end
				S_SEP_PAY: begin
					bad  = data != frame_pkg::CH_US;
					next = (remain == 8'd0) ? S_TAIL_E : S_PAY_HI;
				end
				S_PAY_HI:  begin
					// grouping underscores between bytes are dropped
					bad  = !hex_ok && data != frame_pkg::CH_US;
					next = hex_ok ? S_PAY_LO : S_PAY_HI;
				end
				S_PAY_LO:  begin
					bad  = !hex_ok;
					next = (remain == 8'd1) ? S_TAIL_US : S_PAY_HI;
				end
				S_TAIL_US: begin bad = data != frame_pkg::CH_US; next = S_TAIL_E; end
				S_TAIL_E:  begin bad = data != frame_pkg::CH_E;  next = S_TAIL_F; end
				S_TAIL_F:  begin bad = data != frame_pkg::CH_F;  next = S_HUNT;   end
				default:   next = S_HUNT;
			endcase
			if (bad)
				next = S_HUNT;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= S_HUNT;
			hdr_valid  <= 1'b0;
			pay_valid  <= 1'b0;
			frame_done <= 1'b0;
			frame_err  <= 1'b0;
			remain     <= '0;
		end else begin
			state      <= next;
			frame_err  <= bad;
			hdr_valid  <= rcv && !bad && state == S_CNT_LO;
			pay_valid  <= rcv && !bad && state == S_PAY_LO;
			frame_done <= rcv && !bad && state == S_TAIL_F;
			if (rcv && hex_ok && state == S_CNT_LO)
				remain <= {hi_nib, nib};
			else if (rcv && hex_ok && state == S_PAY_LO)
				remain <= remain - 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rcv && hex_ok) begin
			hi_nib <= nib; // the low-digit states read the previous value first
			if (state == S_CMD_LO)
				hdr.cmd <= frame_pkg::cmd_e'({hi_nib, nib});
			if (state == S_CNT_LO)
				hdr.count <= {hi_nib, nib};
			if (state == S_PAY_LO)
				pay_byte <= {hi_nib, nib};
		end
	end

endmodule

//--- frame_pkg.sv
package frame_pkg;

	typedef enum logic [7:0] {
		SET_DIM  = 8'h01,
		START    = 8'h03,
		LOAD_MAT = 8'h04,
		LOAD_VEC = 8'h05
	} cmd_e;

	typedef struct packed {
		cmd_e       cmd;
		logic [7:0] count; // number of payload bytes that follow
	} frame_hdr_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} payload_t;

	// framing characters
	localparam logic [7:0] CH_F  = 8'h46;
	localparam logic [7:0] CH_E  = 8'h45;
	localparam logic [7:0] CH_US = 8'h5f;

	// hex digit ranges, upper and lower case letters are both accepted
	localparam logic [7:0] CH_0  = 8'h30;
	localparam logic [7:0] CH_9  = 8'h39;
	localparam logic [7:0] CH_A  = 8'h41;
	localparam logic [7:0] CH_LA = 8'h61;
	localparam logic [7:0] CH_LF = 8'h66;

endpackage

//--- mxv_ctrl.sv
`timescale 1ns/1ps

module mxv_ctrl #(
	parameter int MAX_DIM = mxv_pkg::MAX_DIM_DEFAULT
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  hdr_valid,
	input  frame_pkg::frame_hdr_t hdr,
	input  frame_pkg::payload_t   payload,
	input  logic                  frame_done,
	input  logic                  mat_done,
	output logic                  mat_we,
	output logic                  vec_we,
	output mxv_pkg::addr_t        wr_addr,
	output mxv_pkg::elem_t        wr_data,
	output mxv_pkg::dim_t         dim,
	output logic                  start,
	output logic                  busy
);

	frame_pkg::cmd_e cmd;
	mxv_pkg::dim_t   wr_row;
	mxv_pkg::dim_t   wr_col;
	logic [7:0]      new_dim;
	logic            dim_ok;
	logic            go;

	// bytes beyond dim by dim elements are dropped
	assign mat_we  = payload.valid && cmd == frame_pkg::LOAD_MAT && wr_row < dim;
	assign vec_we  = payload.valid && cmd == frame_pkg::LOAD_VEC && wr_col < dim;
	assign wr_addr = {wr_row[mxv_pkg::IDX_W-1:0], wr_col[mxv_pkg::IDX_W-1:0]};
	assign wr_data = payload.data;

	assign dim_ok = new_dim != 8'd0 && new_dim <= MAX_DIM;
	assign go     = frame_done && cmd == frame_pkg::START && !busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			cmd    <= frame_pkg::SET_DIM;
			wr_row <= '0;
			wr_col <= '0;
			dim    <= mxv_pkg::dim_t'(MAX_DIM);
			start  <= 1'b0;
			busy   <= 1'b0;
		end else begin
			if (hdr_valid) begin
				cmd    <= hdr.cmd;
				wr_row <= '0;
				wr_col <= '0;
			end else if (mat_we) begin
				if (wr_col == dim - 3'd1) begin // row-major, wrap at the active width
					wr_col <= '0;
					wr_row <= wr_row + 3'd1;
				end else
					wr_col <= wr_col + 3'd1;
			end else if (vec_we)
				wr_col <= wr_col + 3'd1;
			if (frame_done && cmd == frame_pkg::SET_DIM && dim_ok && !busy)
				dim <= mxv_pkg::dim_t'(new_dim);
			start <= go;
			if (go)
				busy <= 1'b1;
			else if (mat_done)
				busy <= 1'b0;
		end
	end

	// held until the frame proves well formed
	always_ff @(posedge clk)
		if (payload.valid && cmd == frame_pkg::SET_DIM)
			new_dim <= payload.data;

endmodule

//--- mxv_pkg.sv
package mxv_pkg;

	localparam int ELEM_W          = 8;
	localparam int ACC_W           = 20; // 4 * 255 * 255 needs 18 bits
	localparam int IDX_W           = 2;
	localparam int DIM_W           = 3; // must hold MAX_DIM itself
	localparam int MAX_DIM_DEFAULT = 4;

	typedef logic [ELEM_W-1:0] elem_t;
	typedef logic [ACC_W-1:0]  acc_t;

	// row or column index inside the register files
	typedef logic [IDX_W-1:0] idx_t;

	// active dimension, 1 to MAX_DIM
	typedef logic [DIM_W-1:0] dim_t;

	// write address into the store, row in the upper half and column in the lower half
	typedef logic [2*IDX_W-1:0] addr_t;

	typedef struct packed {
		idx_t row;
		acc_t sum;
	} result_t;

endpackage

//--- mxv_top.f
mxv_pkg.sv
frame_pkg.sv
frame_parser.sv
mxv_ctrl.sv
operand_store.sv
row_mac.sv
result_fifo.sv
mxv_top.sv
tb_mxv.sv

//--- mxv_top.sv
`timescale 1ns/1ps

module mxv_top #(
	parameter int MAX_DIM = mxv_pkg::MAX_DIM_DEFAULT
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             rcv,
	input  logic [7:0]       data,
	input  logic             result_pop,
	output logic             result_valid,
	output mxv_pkg::result_t result,
	output logic             frame_err,
	output logic             busy
);

	logic                          hdr_valid;
	frame_pkg::frame_hdr_t         hdr;
	frame_pkg::payload_t           payload;
	logic                          frame_done;
	logic                          mat_we, vec_we;
	mxv_pkg::addr_t                wr_addr;
	mxv_pkg::elem_t                wr_data;
	mxv_pkg::dim_t                 dim;
	logic                          start;
	mxv_pkg::idx_t                 col [MAX_DIM];
	mxv_pkg::elem_t [MAX_DIM-1:0]  row_elems;
	mxv_pkg::elem_t                vec_elem;
	logic [MAX_DIM-1:0]            done;
	mxv_pkg::acc_t [MAX_DIM-1:0]   sums;

	frame_parser u_parser (
		.clk, .rst, .rcv, .data,
		.hdr_valid, .hdr, .payload, .frame_done, .frame_err
	);

	mxv_ctrl #(.MAX_DIM(MAX_DIM)) u_ctrl (
		.clk, .rst, .hdr_valid, .hdr, .payload, .frame_done,
		.mat_done(done[0]),
		.mat_we, .vec_we, .wr_addr, .wr_data, .dim, .start, .busy
	);

	operand_store #(.MAX_DIM(MAX_DIM)) u_store (
		.clk, .rst, .mat_we, .vec_we, .wr_addr, .wr_data,
		.col(col[0]), // all units step in lockstep, row 0 leads
		.row_elems, .vec_elem
	);

	// rows outside the active dimension never start and so never push
	for (genvar i = 0; i < MAX_DIM; i++) begin : g_row
		row_mac u_mac (
			.clk, .rst,
			.start(start && dim > i),
			.dim,
			.a(row_elems[i]),
			.b(vec_elem),
			.col(col[i]),
			.done(done[i]),
			.sum(sums[i])
		);
	end

	result_fifo #(.MAX_DIM(MAX_DIM), .DEPTH(2 * MAX_DIM)) u_fifo (
		.clk, .rst,
		.push(done),
		.row_sums(sums),
		.pop(result_pop),
		.valid(result_valid),
		.head(result)
	);

endmodule

//--- operand_store.sv
`timescale 1ns/1ps

module operand_store #(
	parameter int MAX_DIM = mxv_pkg::MAX_DIM_DEFAULT
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               mat_we,
	input  logic                               vec_we,
	input  mxv_pkg::addr_t                     wr_addr,
	input  mxv_pkg::elem_t                     wr_data,
	input  mxv_pkg::idx_t                      col,
	output mxv_pkg::elem_t [MAX_DIM-1:0]       row_elems,
	output mxv_pkg::elem_t                     vec_elem
);

	mxv_pkg::elem_t mat [MAX_DIM][MAX_DIM];
	mxv_pkg::elem_t vec [MAX_DIM];
	mxv_pkg::idx_t  wr_row;
	mxv_pkg::idx_t  wr_col;

	assign {wr_row, wr_col} = wr_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			mat <= '{default: '{default: '0}};
			vec <= '{default: '0};
		end else begin
			if (mat_we)
				mat[wr_row][wr_col] <= wr_data;
			if (vec_we)
				vec[wr_col] <= wr_data; // vector writes carry row 0
		end
	end

	// one column slice feeds every row unit in the same cycle
	always_comb begin
		for (int r = 0; r < MAX_DIM; r++)
			row_elems[r] = mat[r][col];
	end

	assign vec_elem = vec[col];

endmodule

//--- result_fifo.sv
`timescale 1ns/1ps

module result_fifo #(
	parameter int MAX_DIM = mxv_pkg::MAX_DIM_DEFAULT,
	parameter int DEPTH   = 2 * MAX_DIM
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [MAX_DIM-1:0]            push,
	input  mxv_pkg::acc_t [MAX_DIM-1:0]   row_sums,
	input  logic                          pop,
	output logic                          valid,
	output mxv_pkg::result_t              head
);

	localparam int PW = $clog2(DEPTH);

	mxv_pkg::result_t mem [DEPTH];
	logic [PW-1:0]    rd_ptr, wr_ptr, wr_next;
	logic [PW-1:0]    slot [MAX_DIM];
	logic [MAX_DIM-1:0] take;
	logic [PW:0]      count;
	logic [PW:0]      n_acc;
	logic             do_pop;

	// depth need not be a power of two
	function automatic logic [PW-1:0] wrap(input logic [PW:0] p);
		return (p >= DEPTH) ? PW'(p - DEPTH) : PW'(p);
	endfunction

	assign valid  = count != '0;
	assign head   = mem[rd_ptr];
	assign do_pop = pop && valid;

	// lower rows claim the lower slots, pushes that find no room are lost
	always_comb begin
		n_acc = '0;
		for (int r = 0; r < MAX_DIM; r++) begin
			slot[r] = wrap({1'b0, wr_ptr} + n_acc);
			take[r] = push[r] && (count + n_acc < DEPTH);
			if (take[r])
				n_acc = n_acc + 1'b1;
		end
		wr_next = wrap({1'b0, wr_ptr} + n_acc);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_next;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + n_acc - do_pop;
		end
	end

	always_ff @(posedge clk) begin
		for (int r = 0; r < MAX_DIM; r++)
			if (take[r])
				mem[slot[r]] <= '{row: mxv_pkg::idx_t'(r), sum: row_sums[r]};
	end

endmodule

//--- row_mac.sv
`timescale 1ns/1ps

module row_mac (
	input  logic           clk,
	input  logic           rst,
	input  logic           start,
	input  mxv_pkg::dim_t  dim,
	input  mxv_pkg::elem_t a,
	input  mxv_pkg::elem_t b,
	output mxv_pkg::idx_t  col,
	output logic           done,
	output mxv_pkg::acc_t  sum
);

	logic          run;
	logic          last;
	mxv_pkg::acc_t acc;

	assign last = run && mxv_pkg::dim_t'(col) == dim - 3'd1;
	assign done = last;
	// the final product is folded in combinationally so done lines up with the last column
	assign sum  = acc + mxv_pkg::acc_t'(a) * mxv_pkg::acc_t'(b);

	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
			col <= '0;
		end else if (start) begin
			run <= 1'b1;
			col <= '0;
		end else if (run) begin
			if (last)
				run <= 1'b0;
			else
				col <= col + 2'd1;
		end
	end

	always_ff @(posedge clk)
		if (start)
			acc <= '0;
		else if (run)
			acc <= sum;

endmodule

//--- tb_mxv.sv
`timescale 1ns/1ps

module tb_mxv;

	localparam int MAX_DIM = 4;

	logic             clk;
	logic             rst;
	logic             rcv;
	logic [7:0]       data;
	logic             result_pop;
	logic             result_valid;
	mxv_pkg::result_t result;
	logic             frame_err;
	logic             busy;

	// stimulus table with one entry per frame
	string frames[$];
	bit    bad[$];    // frame_err expected
	int    gaps[$];   // idle cycles after each character
	bit    drains[$]; // pop and compare results after this frame

	// reference model state
	int m_dim;
	int m_mat [MAX_DIM][MAX_DIM];
	int m_vec [MAX_DIM];
	int exp_row[$];
	int exp_sum[$];

	logic [31:0] rng_state = 32'h017f_0c19;
	int          err_seen  = 0;
	int          busy_len  = 0;
	int          cycles    = 0;
	int          limit     = 0;
	int          errs_before;

	mxv_top #(.MAX_DIM(MAX_DIM)) u_dut (
		.clk, .rst, .rcv, .data, .result_pop,
		.result_valid, .result, .frame_err, .busy
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
			stop_run($sformatf("Timeout: the run did not finish within %0d cycles", limit));
	end

	always @(negedge clk)
		if (frame_err)
			err_seen <= err_seen + 1;

	// busy spans start through the push cycle and so lasts dim plus one cycles
	always @(negedge clk) begin
		if (busy) begin
			busy_len <= busy_len + 1;
		end else if (busy_len != 0) begin
			assert (busy_len == m_dim + 1 && result_valid)
			else stop_run($sformatf("Error at %0t ns: busy lasted %0d cycles, result_valid %0b",
				$time, busy_len, result_valid));
			busy_len <= 0;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int next_byte();
		rng_state = xorshift(rng_state);
		return int'(rng_state[7:0]);
	endfunction

	function automatic int hex_digit(input byte c);
		if (c >= "0" && c <= "9")
			return c - "0";
		if (c >= "a" && c <= "f")
			return c - "a" + 10;
		return c - "A" + 10;
	endfunction

	// random loads use lower-case hex digits
	function automatic string rand_load(input int cmd, input int n);
		string s;
		s = $sformatf("FE_%02x_%02x_", cmd, n);
		for (int i = 0; i < n; i++)
			s = {s, $sformatf("%02x", next_byte())};
		return {s, "_EF"};
	endfunction

	task automatic add_frame(input string s, input bit err, input int gap, input bit drain);
		frames.push_back(s);
		bad.push_back(err);
		gaps.push_back(gap);
		drains.push_back(drain);
	endtask

	task automatic build_table();
		// reference sequence with grouping underscores inside the matrix payload
		add_frame("FE_01_01_03_EF", 0, 2, 0);
		add_frame("FE_04_09_010203_010203_010203_EF", 0, 1, 0);
		add_frame("FE_05_03_040404_EF", 0, 1, 0);
		add_frame("FE_03_00_EF", 0, 2, 1);
		// random loads at dimension 2 and 4
		add_frame("FE_01_01_02_EF", 0, 3, 0);
		add_frame(rand_load(4, 4), 0, 1, 0);
		add_frame(rand_load(5, 2), 0, 2, 0);
		add_frame("FE_03_00_EF", 0, 1, 1);
		add_frame("FE_01_01_04_EF", 0, 1, 0);
		add_frame(rand_load(4, 16), 0, 0, 0);
		add_frame(rand_load(5, 4), 0, 3, 0);
		add_frame("FE_03_00_EF", 0, 1, 1);
		// malformed frames leave the stored operands alone
		add_frame("FE_05_0G_111111_EE", 1, 1, 0);
		add_frame("FE_03_00_EE", 1, 1, 0); // wrong terminator
		add_frame("FE_03_0x_EE", 1, 2, 0);
		add_frame("FE_03_00_EF", 0, 1, 1);
		// out-of-range dimensions keep the last valid one
		add_frame("FE_01_01_03_EF", 0, 1, 0);
		add_frame("FE_01_01_00_EF", 0, 1, 0);
		add_frame("FE_01_01_05_EF", 0, 2, 0);
		add_frame("FE_03_00_EF", 0, 1, 1);
		// two starts back to back are drained together
		add_frame("FE_03_00_EF", 0, 0, 0);
		add_frame("FE_03_00_EF", 0, 0, 1);
	endtask

	task automatic apply_model(input string s);
		int cmd;
		int cnt;
		int i;
		int k;
		int v;
		int sum;
		cmd = hex_digit(s[3]) * 16 + hex_digit(s[4]);
		cnt = hex_digit(s[6]) * 16 + hex_digit(s[7]);
		i = 9;
		k = 0;
		while (k < cnt) begin
			if (s[i] == "_") begin
				i++;
			end else begin
				v = hex_digit(s[i]) * 16 + hex_digit(s[i+1]);
				i += 2;
				case (cmd)
					1: if (v >= 1 && v <= MAX_DIM) m_dim = v;
					4: if (k / m_dim < m_dim) m_mat[k / m_dim][k % m_dim] = v;
					5: if (k < m_dim) m_vec[k] = v;
					default: ;
				endcase
				k++;
			end
		end
		if (cmd == 3) begin
			for (int r = 0; r < m_dim; r++) begin
				sum = 0;
				for (int c = 0; c < m_dim; c++)
					sum += m_mat[r][c] * m_vec[c];
				exp_row.push_back(r);
				exp_sum.push_back(sum);
			end
		end
	endtask

	task automatic send_frame(input string s, input int gap);
		for (int i = 0; i < s.len(); i++) begin
			@(posedge clk);
			rcv  <= 1'b1;
			data <= s[i];
			repeat (gap) begin
				@(posedge clk);
				rcv <= 1'b0;
			end
		end
		@(posedge clk);
		rcv <= 1'b0;
	endtask

	task automatic drain_results();
		int r;
		int s;
		while (exp_row.size() > 0) begin
			@(negedge clk);
			if (result_valid) begin
				r = exp_row.pop_front();
				s = exp_sum.pop_front();
				assert (result.row == r && result.sum == s)
				else stop_run($sformatf("Error at %0t ns: row %0d sum %0d, expected row %0d sum %0d",
					$time, result.row, result.sum, r, s));
				@(posedge clk);
				result_pop <= 1'b1;
				@(posedge clk);
				result_pop <= 1'b0;
			end
		end
		while (busy)
			@(negedge clk);
		@(negedge clk);
		assert (!result_valid)
		else stop_run($sformatf("Error at %0t ns: FIFO holds more results than expected", $time));
	endtask

	initial begin
		rcv        = 1'b0;
		data       = 8'h00;
		result_pop = 1'b0;
		rst        = 1'b1;
		m_dim      = MAX_DIM;
		m_mat      = '{default: '{default: 0}};
		m_vec      = '{default: 0};
		build_table();
		limit = 40;
		for (int n = 0; n < frames.size(); n++) begin
			limit += frames[n].len() * (gaps[n] + 1) + 6;
			if (drains[n])
				limit += 2 * MAX_DIM * 3 + 20;
		end
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!result_valid && !busy && !frame_err)
		else stop_run($sformatf("Error at %0t ns: outputs not idle after reset", $time));
		for (int n = 0; n < frames.size(); n++) begin
			errs_before = err_seen;
			send_frame(frames[n], gaps[n]);
			repeat (3) @(posedge clk); // let a late frame_err pulse land
			assert (err_seen - errs_before == (bad[n] ? 1 : 0))
			else stop_run($sformatf("Error at %0t ns: frame %0d gave %0d frame_err pulses",
				$time, n, err_seen - errs_before));
			if (!bad[n])
				apply_model(frames[n]);
			if (drains[n])
				drain_results();
		end
		$display("Simulation passed");
		$finish;
	end

endmodule
